// ==== src/rename_pkg.sv ====
package rename_pkg;

    // ========================================
    // sizes
    // ========================================
    localparam int ARCH_REGS  = 32;
    localparam int PHYS_REGS  = 64;
    localparam int CKPT_PAGES = 8;
    localparam int FREE_SLOTS = PHYS_REGS - ARCH_REGS;   // tags not mapped at reset

    localparam int ARCH_W   = $clog2(ARCH_REGS);
    localparam int TAG_W    = 8;
    localparam int PAGE_W   = $clog2(CKPT_PAGES);
    localparam int FL_IDX_W = $clog2(FREE_SLOTS);        // slot index inside the queue
    localparam int FL_PTR_W = $clog2(PHYS_REGS) + 1;     // free running, difference gives fill

    // ========================================
    // types
    // ========================================
    typedef logic [ARCH_W-1:0]   arch_reg_t;
    typedef logic [TAG_W-1:0]    phys_tag_t;
    typedef logic [PAGE_W-1:0]   page_t;
    typedef logic [FL_PTR_W-1:0] fl_ptr_t;

    // RV32 major opcodes that the decoder tells apart
    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OP_IMM = 7'b0010011,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011,
        OP     = 7'b0110011,
        LUI    = 7'b0110111,
        BRANCH = 7'b1100011,
        JALR   = 7'b1100111,
        JAL    = 7'b1101111
    } opcode_e;

    // ========================================
    // marker tags
    // ========================================
    localparam phys_tag_t NO_SRC_TAG  = 8'hFE;   // source operand not read
    localparam phys_tag_t NO_DEST_TAG = 8'hFF;   // nothing written

endpackage

// ==== src/instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic [31:0]           in_instr,
    input  logic                  stall,
    input  logic                  flush,
    output logic                  dec_valid,
    output rename_pkg::arch_reg_t dec_rs1,
    output rename_pkg::arch_reg_t dec_rs2,
    output rename_pkg::arch_reg_t dec_rd,
    output logic                  dec_use_rs1,
    output logic                  dec_use_rs2,
    output logic                  dec_has_rd
);

    rename_pkg::opcode_e   opcode;
    rename_pkg::arch_reg_t rs1_field;
    rename_pkg::arch_reg_t rs2_field;
    rename_pkg::arch_reg_t rd_field;
    logic                  use_rs1;
    logic                  use_rs2;
    logic                  has_rd;

    assign opcode    = rename_pkg::opcode_e'(in_instr[6:0]);
    assign rs1_field = in_instr[19:15];
    assign rs2_field = in_instr[24:20];
    assign rd_field  = in_instr[11:7];

    // ========================================
    // operand class
    // ========================================
    always_comb begin
        case (opcode)
            rename_pkg::LUI, rename_pkg::AUIPC, rename_pkg::JAL: begin
                use_rs1 = 1'b0;
                use_rs2 = 1'b0;
            end
            rename_pkg::JALR, rename_pkg::LOAD, rename_pkg::OP_IMM: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b0;
            end
            default: begin   // R type, stores, branches and anything unknown
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
        endcase
    end

    // x0 is hardwired so a write to it gets no new tag
    assign has_rd = (opcode != rename_pkg::STORE) && (opcode != rename_pkg::BRANCH) &&
                    (rd_field != '0);

    // ========================================
    // stage register
    // ========================================
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            dec_valid <= 1'b0;   // a restore throws away whatever sits here
        end else if (!stall) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            dec_rs1     <= rs1_field;
            dec_rs2     <= rs2_field;
            dec_rd      <= rd_field;
            dec_use_rs1 <= use_rs1;
            dec_use_rs2 <= use_rs2;
            dec_has_rd  <= has_rd;
        end
    end

    dec_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(dec_valid));

endmodule

// ==== src/map_table.sv ====
`timescale 1ns/1ns

module map_table (
    input  logic                    clk,
    input  logic                    reset,

    // lookup for the two sources and the current mapping of rd
    input  rename_pkg::arch_reg_t   raddr1,
    input  rename_pkg::arch_reg_t   raddr2,
    input  rename_pkg::arch_reg_t   raddr_rd,
    output rename_pkg::phys_tag_t   rd_tag1,
    output rename_pkg::phys_tag_t   rd_tag2,
    output rename_pkg::phys_tag_t   rd_old,

    // new mapping from rename
    input  logic                    we,
    input  rename_pkg::arch_reg_t   waddr,
    input  rename_pkg::phys_tag_t   wtag,

    // checkpoint control
    input  logic                    save,
    input  rename_pkg::page_t       save_page,
    input  logic                    restore,
    input  rename_pkg::page_t       restore_page
);

    rename_pkg::phys_tag_t map_q  [rename_pkg::ARCH_REGS];
    rename_pkg::phys_tag_t page_q [rename_pkg::CKPT_PAGES][rename_pkg::ARCH_REGS];
    logic                  save_ok;

    // ========================================
    // read ports
    // ========================================
    assign rd_tag1 = map_q[raddr1];
    assign rd_tag2 = map_q[raddr2];
    assign rd_old  = map_q[raddr_rd];

    // the restore wins when both strobes name the same page
    assign save_ok = save && !(restore && (restore_page == save_page));

    // ========================================
    // live table
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_tag_t'(i);   // identity mapping
            end
        end else if (restore) begin
            map_q <= page_q[restore_page];
        end else if (we) begin
            map_q[waddr] <= wtag;
        end
    end

    // ========================================
    // checkpoint pages
    // ========================================
    // the page takes the table as it was before this edge, so a rename
    // in the same cycle is not part of the snapshot
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < rename_pkg::CKPT_PAGES; p++) begin
                for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                    page_q[p][i] <= '0;
                end
            end
        end else if (save_ok) begin
            page_q[save_page] <= map_q;
        end
    end

    // rename is held off during a restore, so the two never meet
    no_write_on_restore: assert property (@(posedge clk) disable iff (reset)
        !(we && restore));

endmodule

// ==== src/free_list.sv ====
`timescale 1ns/1ns

module free_list (
    input  logic                  clk,
    input  logic                  reset,

    // allocation side
    input  logic                  alloc,
    output rename_pkg::phys_tag_t head_tag,
    output logic                  empty,

    // tags coming back from the core
    input  logic                  release_valid,
    input  rename_pkg::phys_tag_t release_tag,

    // checkpoint control
    input  logic                  save,
    input  rename_pkg::page_t     save_page,
    input  logic                  restore,
    input  rename_pkg::page_t     restore_page
);

    rename_pkg::phys_tag_t slot_q [rename_pkg::FREE_SLOTS];
    rename_pkg::fl_ptr_t   rd_ptr;
    rename_pkg::fl_ptr_t   wr_ptr;
    rename_pkg::fl_ptr_t   rd_ptr_page [rename_pkg::CKPT_PAGES];
    rename_pkg::fl_ptr_t   used;
    logic                  full;
    logic                  save_ok;

    // pointers run free and their difference is the fill level
    assign used     = wr_ptr - rd_ptr;
    assign empty    = (used == '0);
    assign full     = (used == rename_pkg::fl_ptr_t'(rename_pkg::FREE_SLOTS));
    assign head_tag = slot_q[rd_ptr[rename_pkg::FL_IDX_W-1:0]];

    assign save_ok = save && !(restore && (restore_page == save_page));

    // ========================================
    // tag storage
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::FREE_SLOTS; i++) begin
                slot_q[i] <= rename_pkg::phys_tag_t'(rename_pkg::ARCH_REGS + i);
            end
        end else if (release_valid) begin
            slot_q[wr_ptr[rename_pkg::FL_IDX_W-1:0]] <= release_tag;
        end
    end

    // ========================================
    // pointers
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= rename_pkg::fl_ptr_t'(rename_pkg::FREE_SLOTS);   // a whole lap ahead
        end else begin
            if (restore) begin
                rd_ptr <= rd_ptr_page[restore_page];   // tail is left where it is
            end else if (alloc) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (release_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int p = 0; p < rename_pkg::CKPT_PAGES; p++) begin
                rd_ptr_page[p] <= '0;
            end
        end else if (save_ok) begin
            rd_ptr_page[save_page] <= rd_ptr;
        end
    end

    no_alloc_when_empty: assert property (@(posedge clk) disable iff (reset)
        !(alloc && empty));

    // a release into a full queue means a tag was freed twice
    no_release_when_full: assert property (@(posedge clk) disable iff (reset)
        !(release_valid && full));

endmodule

// ==== src/rename_stage.sv ====
`timescale 1ns/1ns

module rename_stage (
    input  logic                  clk,
    input  logic                  reset,

    // from decode
    input  logic                  dec_valid,
    input  rename_pkg::arch_reg_t dec_rs1,
    input  rename_pkg::arch_reg_t dec_rs2,
    input  rename_pkg::arch_reg_t dec_rd,
    input  logic                  dec_use_rs1,
    input  logic                  dec_use_rs2,
    input  logic                  dec_has_rd,
    input  logic                  flush,

    // map table
    output rename_pkg::arch_reg_t tab_raddr1,
    output rename_pkg::arch_reg_t tab_raddr2,
    output rename_pkg::arch_reg_t tab_raddr_rd,
    input  rename_pkg::phys_tag_t rd_tag1,
    input  rename_pkg::phys_tag_t rd_tag2,
    input  rename_pkg::phys_tag_t rd_old,
    output logic                  tab_we,
    output rename_pkg::arch_reg_t tab_waddr,
    output rename_pkg::phys_tag_t tab_wtag,

    // free list
    output logic                  alloc,
    input  rename_pkg::phys_tag_t head_tag,
    input  logic                  empty,

    output logic                  stall,
    output logic                  out_valid,
    output rename_pkg::phys_tag_t out_src1_tag,
    output rename_pkg::phys_tag_t out_src2_tag,
    output rename_pkg::phys_tag_t out_dest_tag,
    output rename_pkg::phys_tag_t out_old_tag
);

    logic                  fire;
    rename_pkg::phys_tag_t src1_tag;
    rename_pkg::phys_tag_t src2_tag;
    rename_pkg::phys_tag_t dest_tag;
    rename_pkg::phys_tag_t old_tag;

    assign tab_raddr1   = dec_rs1;
    assign tab_raddr2   = dec_rs2;
    assign tab_raddr_rd = dec_rd;

    // ========================================
    // allocation and stall
    // ========================================
    assign stall = dec_valid && dec_has_rd && empty;   // no tag left for rd
    assign fire  = dec_valid && !stall && !flush;

    assign alloc     = fire && dec_has_rd;
    assign tab_we    = fire && dec_has_rd;
    assign tab_waddr = dec_rd;
    assign tab_wtag  = head_tag;

    assign src1_tag = dec_use_rs1 ? rd_tag1 : rename_pkg::NO_SRC_TAG;
    assign src2_tag = dec_use_rs2 ? rd_tag2 : rename_pkg::NO_SRC_TAG;
    assign dest_tag = dec_has_rd ? head_tag : rename_pkg::NO_DEST_TAG;
    assign old_tag  = dec_has_rd ? rd_old : rename_pkg::NO_DEST_TAG;   // nothing to free later

    // ========================================
    // output register
    // ========================================
    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= fire;
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            out_src1_tag <= src1_tag;
            out_src2_tag <= src2_tag;
            out_dest_tag <= dest_tag;
            out_old_tag  <= old_tag;
        end
    end

    // every tag handed out by the free list must name a real register
    dest_in_range: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_dest_tag != rename_pkg::NO_DEST_TAG)
            |-> (out_dest_tag < rename_pkg::PHYS_REGS));

endmodule

// ==== src/rename_top.sv ====
`timescale 1ns/1ns

module rename_top (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  in_valid,
    input  logic [31:0]           in_instr,
    output logic                  in_ready,
    input  logic                  ckpt_save,
    input  rename_pkg::page_t     ckpt_save_page,
    input  logic                  ckpt_restore,
    input  rename_pkg::page_t     ckpt_restore_page,
    input  logic                  release_valid,
    input  rename_pkg::phys_tag_t release_tag,
    output logic                  out_valid,
    output rename_pkg::phys_tag_t out_src1_tag,
    output rename_pkg::phys_tag_t out_src2_tag,
    output rename_pkg::phys_tag_t out_dest_tag,
    output rename_pkg::phys_tag_t out_old_tag
);

    logic                  dec_valid;
    rename_pkg::arch_reg_t dec_rs1;
    rename_pkg::arch_reg_t dec_rs2;
    rename_pkg::arch_reg_t dec_rd;
    logic                  dec_use_rs1;
    logic                  dec_use_rs2;
    logic                  dec_has_rd;
    logic                  stall;

    rename_pkg::arch_reg_t tab_raddr1;
    rename_pkg::arch_reg_t tab_raddr2;
    rename_pkg::arch_reg_t tab_raddr_rd;
    rename_pkg::phys_tag_t rd_tag1;
    rename_pkg::phys_tag_t rd_tag2;
    rename_pkg::phys_tag_t rd_old;
    logic                  tab_we;
    rename_pkg::arch_reg_t tab_waddr;
    rename_pkg::phys_tag_t tab_wtag;

    logic                  alloc;
    rename_pkg::phys_tag_t head_tag;
    logic                  empty;

    assign in_ready = !stall;

    // ========================================
    // stage one
    // ========================================
    instr_decode decode0 (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .stall       (stall),
        .flush       (ckpt_restore),   // a restore drops the instruction in decode
        .dec_valid   (dec_valid),
        .dec_rs1     (dec_rs1),
        .dec_rs2     (dec_rs2),
        .dec_rd      (dec_rd),
        .dec_use_rs1 (dec_use_rs1),
        .dec_use_rs2 (dec_use_rs2),
        .dec_has_rd  (dec_has_rd)
    );

    // ========================================
    // stage two
    // ========================================
    rename_stage rename0 (
        .clk          (clk),
        .reset        (reset),
        .dec_valid    (dec_valid),
        .dec_rs1      (dec_rs1),
        .dec_rs2      (dec_rs2),
        .dec_rd       (dec_rd),
        .dec_use_rs1  (dec_use_rs1),
        .dec_use_rs2  (dec_use_rs2),
        .dec_has_rd   (dec_has_rd),
        .flush        (ckpt_restore),
        .tab_raddr1   (tab_raddr1),
        .tab_raddr2   (tab_raddr2),
        .tab_raddr_rd (tab_raddr_rd),
        .rd_tag1      (rd_tag1),
        .rd_tag2      (rd_tag2),
        .rd_old       (rd_old),
        .tab_we       (tab_we),
        .tab_waddr    (tab_waddr),
        .tab_wtag     (tab_wtag),
        .alloc        (alloc),
        .head_tag     (head_tag),
        .empty        (empty),
        .stall        (stall),
        .out_valid    (out_valid),
        .out_src1_tag (out_src1_tag),
        .out_src2_tag (out_src2_tag),
        .out_dest_tag (out_dest_tag),
        .out_old_tag  (out_old_tag)
    );

    map_table rat0 (
        .clk          (clk),
        .reset        (reset),
        .raddr1       (tab_raddr1),
        .raddr2       (tab_raddr2),
        .raddr_rd     (tab_raddr_rd),
        .rd_tag1      (rd_tag1),
        .rd_tag2      (rd_tag2),
        .rd_old       (rd_old),
        .we           (tab_we),
        .waddr        (tab_waddr),
        .wtag         (tab_wtag),
        .save         (ckpt_save),
        .save_page    (ckpt_save_page),
        .restore      (ckpt_restore),
        .restore_page (ckpt_restore_page)
    );

    free_list fl0 (
        .clk           (clk),
        .reset         (reset),
        .alloc         (alloc),
        .head_tag      (head_tag),
        .empty         (empty),
        .release_valid (release_valid),
        .release_tag   (release_tag),
        .save          (ckpt_save),
        .save_page     (ckpt_save_page),
        .restore       (ckpt_restore),
        .restore_page  (ckpt_restore_page)
    );

endmodule

// ==== verification/tb_rename.sv ====
`timescale 1ns/1ns

module tb_rename;

    localparam int TEST_CYCLES = 1000;   // rough cycle count of all tests together
    localparam int WAIT_LIMIT  = 20;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid;
    logic [31:0]           in_instr;
    logic                  in_ready;
    logic                  ckpt_save;
    rename_pkg::page_t     ckpt_save_page;
    logic                  ckpt_restore;
    rename_pkg::page_t     ckpt_restore_page;
    logic                  release_valid;
    rename_pkg::phys_tag_t release_tag;
    logic                  out_valid;
    rename_pkg::phys_tag_t out_src1_tag;
    rename_pkg::phys_tag_t out_src2_tag;
    rename_pkg::phys_tag_t out_dest_tag;
    rename_pkg::phys_tag_t out_old_tag;

    // ========================================
    // reference model
    // ========================================
    rename_pkg::phys_tag_t model_map [rename_pkg::ARCH_REGS];
    rename_pkg::phys_tag_t saved_map [rename_pkg::CKPT_PAGES][rename_pkg::ARCH_REGS];
    int                    saved_idx [rename_pkg::CKPT_PAGES];
    rename_pkg::phys_tag_t tag_log [$];   // every tag ever put on the free list in arrival order
    int                    alloc_idx;     // next entry of tag_log to hand out
    rename_pkg::phys_tag_t pending [$];   // replaced tags not yet given back
    rename_pkg::phys_tag_t exp_src1;
    rename_pkg::phys_tag_t exp_src2;
    rename_pkg::phys_tag_t exp_dest;
    rename_pkg::phys_tag_t exp_old;
    integer                seed = 32'h3b312a06;

    rename_top dut0 (.*);

    always #4 clk = ~clk;

    initial begin
        #(TEST_CYCLES * 4 * 8);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1, "simulation timeout");
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "gave up waiting on the DUT");
    endtask

    function automatic logic [31:0] make_instr(input logic [6:0] opc, input int rd,
                                               input int rs1, input int rs2);
        return {7'b0, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], opc};
    endfunction

    task automatic apply_reset();
        reset = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
            model_map[i] = rename_pkg::phys_tag_t'(i);
        end
        tag_log.delete();
        for (int i = 0; i < rename_pkg::FREE_SLOTS; i++) begin
            tag_log.push_back(rename_pkg::phys_tag_t'(rename_pkg::ARCH_REGS + i));
        end
        alloc_idx = 0;
        pending.delete();
        check_value(32'(in_ready), 1, "in_ready after reset");
        check_value(32'(out_valid), 0, "out_valid after reset");
    endtask

    // decode rule and rename of one instruction against the model
    task automatic predict(input logic [31:0] instr);
        logic [6:0]            opc;
        rename_pkg::arch_reg_t rd;
        logic                  use1;
        logic                  use2;
        logic                  writes;
        opc    = instr[6:0];
        rd     = instr[11:7];
        use1   = !(opc == rename_pkg::LUI || opc == rename_pkg::AUIPC ||
                   opc == rename_pkg::JAL);
        use2   = use1 && !(opc == rename_pkg::JALR || opc == rename_pkg::LOAD ||
                           opc == rename_pkg::OP_IMM);
        writes = (opc != rename_pkg::STORE) && (opc != rename_pkg::BRANCH) && (rd != 5'd0);
        exp_src1 = use1 ? model_map[instr[19:15]] : rename_pkg::NO_SRC_TAG;
        exp_src2 = use2 ? model_map[instr[24:20]] : rename_pkg::NO_SRC_TAG;
        if (writes) begin
            exp_dest      = tag_log[alloc_idx];
            exp_old       = model_map[rd];
            model_map[rd] = exp_dest;
            alloc_idx++;
            pending.push_back(exp_old);
        end else begin
            exp_dest = rename_pkg::NO_DEST_TAG;
            exp_old  = rename_pkg::NO_DEST_TAG;
        end
    endtask

    // ========================================
    // stimulus and response
    // ========================================
    task automatic send_instr(input logic [31:0] instr);
        int waited;
        waited   = 0;
        in_valid = 1'b1;
        in_instr = instr;
        while (!in_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("in_ready stayed low, nothing accepted");
        end
        @(posedge clk);   // accepted at this edge
        #1;
        in_valid = 1'b0;
    endtask

    task automatic collect_result();
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) stop_on_timeout("out_valid never came for an instruction");
        end while (!out_valid);
        check_value(32'(out_src1_tag), 32'(exp_src1), "source 1 tag");
        check_value(32'(out_src2_tag), 32'(exp_src2), "source 2 tag");
        check_value(32'(out_dest_tag), 32'(exp_dest), "destination tag");
        check_value(32'(out_old_tag), 32'(exp_old), "old tag");
    endtask

    task automatic run_instr(input logic [31:0] instr);
        predict(instr);
        send_instr(instr);
        collect_result();
    endtask

    task automatic release_oldest();
        release_valid = 1'b1;
        release_tag   = pending.pop_front();
        tag_log.push_back(release_tag);
        @(posedge clk);
        #1;
        release_valid = 1'b0;
    endtask

    task automatic take_checkpoint(input logic save, input logic restore,
                                   input rename_pkg::page_t page);
        ckpt_save         = save;
        ckpt_restore      = restore;
        ckpt_save_page    = page;
        ckpt_restore_page = page;
        @(posedge clk);
        #1;
        ckpt_save    = 1'b0;
        ckpt_restore = 1'b0;
        if (restore) begin   // restore wins over a save to the same page
            model_map = saved_map[page];
            alloc_idx = saved_idx[page];
        end else if (save) begin
            saved_map[page] = model_map;
            saved_idx[page] = alloc_idx;
        end
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic mapping_after_reset();
        apply_reset();
        run_instr(make_instr(rename_pkg::OP, 1, 5, 9));
        check_value(32'(out_src1_tag), 5, "x5 after reset");
        check_value(32'(out_src2_tag), 9, "x9 after reset");
        run_instr(make_instr(rename_pkg::STORE, 4, 2, 3));
        check_value(32'(out_dest_tag), 32'hFF, "store destination");
        run_instr(make_instr(rename_pkg::LUI, 6, 7, 8));
        check_value(32'(out_src1_tag), 32'hFE, "lui source 1");
        check_value(32'(out_src2_tag), 32'hFE, "lui source 2");
    endtask

    task automatic dest_chain();
        apply_reset();
        for (int i = 0; i < 3; i++) begin
            run_instr(make_instr(rename_pkg::OP, 3, 1, 2));
            check_value(32'(out_dest_tag), 32 + i, "chain destination");
            check_value(32'(out_old_tag), (i == 0) ? 3 : 31 + i, "chain old tag");
        end
        run_instr(make_instr(rename_pkg::OP, 5, 3, 3));
        check_value(32'(out_src1_tag), 34, "read of x3 after chain");
        run_instr(make_instr(rename_pkg::OP, 0, 1, 1));   // x0 keeps no mapping
        run_instr(make_instr(rename_pkg::OP, 6, 1, 1));
        check_value(32'(out_dest_tag), 36, "destination after x0 write");
    endtask

    task automatic operand_classes();
        apply_reset();
        run_instr(make_instr(rename_pkg::JALR, 1, 4, 7));
        check_value(32'(out_src2_tag), 32'hFE, "jalr source 2");
        run_instr(make_instr(rename_pkg::LOAD, 2, 4, 7));
        check_value(32'(out_src2_tag), 32'hFE, "load source 2");
        run_instr(make_instr(rename_pkg::OP_IMM, 3, 4, 7));
        check_value(32'(out_src2_tag), 32'hFE, "op-imm source 2");
        run_instr(make_instr(rename_pkg::BRANCH, 9, 4, 7));
        check_value(32'(out_dest_tag), 32'hFF, "branch destination");
        run_instr(make_instr(rename_pkg::AUIPC, 10, 4, 7));
        run_instr(make_instr(rename_pkg::JAL, 11, 4, 7));
    endtask

    task automatic checkpoint_restore();
        apply_reset();
        run_instr(make_instr(rename_pkg::OP, 1, 0, 0));
        take_checkpoint(1'b1, 1'b0, 3'd2);
        run_instr(make_instr(rename_pkg::OP, 1, 1, 0));
        run_instr(make_instr(rename_pkg::OP_IMM, 2, 1, 0));
        run_instr(make_instr(rename_pkg::LUI, 3, 0, 0));
        take_checkpoint(1'b0, 1'b1, 3'd2);
        run_instr(make_instr(rename_pkg::OP, 4, 1, 2));
        check_value(32'(out_src1_tag), 32, "x1 after restore");
        check_value(32'(out_src2_tag), 2, "x2 after restore");
        check_value(32'(out_dest_tag), 33, "first destination after restore");
        take_checkpoint(1'b1, 1'b1, 3'd2);
        run_instr(make_instr(rename_pkg::OP, 5, 4, 1));
        // page 2 must still hold the snapshot from before the clash
        take_checkpoint(1'b0, 1'b1, 3'd2);
        run_instr(make_instr(rename_pkg::OP, 6, 4, 5));
        check_value(32'(out_src1_tag), 4, "x4 after restore that beat a save");
        check_value(32'(out_dest_tag), 33, "destination after restore that beat a save");
    endtask

    task automatic stall_until_release();
        logic [31:0] instr;
        apply_reset();
        for (int i = 0; i < rename_pkg::FREE_SLOTS; i++) begin
            run_instr(make_instr(rename_pkg::OP, 7, 7, 0));
        end
        instr = make_instr(rename_pkg::OP, 8, 7, 7);
        send_instr(instr);
        repeat (3) begin
            check_value(32'(in_ready), 0, "in_ready with the free list empty");
            check_value(32'(out_valid), 0, "out_valid while stalled");
            @(posedge clk);
            #1;
        end
        release_oldest();   // gives back tag 7 which x7 held at reset
        predict(instr);
        collect_result();
        check_value(32'(out_dest_tag), 7, "destination after release");
    endtask

    task automatic random_stream();
        logic [6:0]  kinds [9];
        logic [31:0] rnd;
        logic [31:0] instr;
        kinds = '{rename_pkg::LOAD, rename_pkg::OP_IMM, rename_pkg::AUIPC,
                  rename_pkg::STORE, rename_pkg::OP, rename_pkg::LUI,
                  rename_pkg::BRANCH, rename_pkg::JALR, rename_pkg::JAL};
        apply_reset();
        for (int n = 0; n < 200; n++) begin
            rnd   = $random(seed);
            instr = {7'b0, rnd[14:10], rnd[9:5], 3'b000, rnd[4:0],
                     kinds[int'(rnd[31:28]) % 9]};
            if (alloc_idx == tag_log.size()) release_oldest();   // keep rename from stalling
            run_instr(instr);
            if (pending.size() != 0 && rnd[20]) release_oldest();
        end
    endtask

    initial begin
        reset             = 1'b1;
        in_valid          = 1'b0;
        in_instr          = '0;
        ckpt_save         = 1'b0;
        ckpt_save_page    = '0;
        ckpt_restore      = 1'b0;
        ckpt_restore_page = '0;
        release_valid     = 1'b0;
        release_tag       = '0;
        mapping_after_reset();
        dest_chain();
        operand_classes();
        checkpoint_restore();
        stall_until_release();
        random_stream();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== compile.f ====
src/rename_pkg.sv
src/instr_decode.sv
src/map_table.sv
src/free_list.sv
src/rename_stage.sv
src/rename_top.sv
verification/tb_rename.sv

// ==== run.sh ====
#!/bin/sh
# builds the rename testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_rename \
    -o sim_rename || exit 1
sim_out=$(./obj_dir/sim_rename)
echo "$sim_out"
echo "$sim_out" | grep -q "Test completed successfully" && echo "PASS" || { echo "FAIL"; exit 1; }
